/* common/nabp_defines.svh */
`ifndef NABP_DEFINES_SVH
`define NABP_DEFINES_SVH

// shift phase length, one image row
`define NABP_IMAGE_SIZE 8

// fill phase length, preload of the mapper
`define NABP_FILL_LEN 4

`define NABP_ANGLE_WIDTH 3

// fraction bits of slope and accumulator
`define NABP_FRAC_WIDTH 3

// must hold NABP_IMAGE_SIZE
`define NABP_ACCU_INT_WIDTH 4

`define NABP_SAMPLE_WIDTH 8
`define NABP_MAPPER_DEPTH 8

`endif

/* common/nabp_fixed_pkg.sv */
`default_nettype none

`include "nabp_defines.svh"

package nabp_fixed_pkg;

    // integer and fraction split of the row accumulator
    typedef struct packed {
        logic [`NABP_ACCU_INT_WIDTH-1:0] int_part;
        logic [`NABP_FRAC_WIDTH-1:0]     frac_part;
    } accu_fields_t;

    // summed as raw bits, read back as fields for carry detect
    typedef union packed {
        logic [`NABP_ACCU_INT_WIDTH+`NABP_FRAC_WIDTH-1:0] raw;
        accu_fields_t                                     fields;
    } accu_word_t;

    // 1.3 unsigned, slope in eighths of a pixel per row
    typedef logic [`NABP_FRAC_WIDTH:0] slope_t;

endpackage

`default_nettype wire

/* common/nabp_state_pkg.sv */
`default_nettype none

package nabp_state_pkg;

    // per-angle sequence, fill then shift
    typedef enum logic [1:0] {
        ready_s     = 2'd0,
        fill_s      = 2'd1,
        fill_done_s = 2'd2,
        shift_s     = 2'd3
    } shifter_state_t;

endpackage

`default_nettype wire

/* rtl/nabp_slope_table.sv */
`timescale 1ns/1ns
`default_nettype none

`include "nabp_defines.svh"

module nabp_slope_table
(
    input  logic [`NABP_ANGLE_WIDTH-1:0] angle,
    output nabp_fixed_pkg::slope_t       slope
);

    // roughly 8*tan(angle*pi/32), never below one eighth
    always_comb
    begin
        case (angle)
            3'd0:    slope = 4'd1;
            3'd1:    slope = 4'd1;
            3'd2:    slope = 4'd2;
            3'd3:    slope = 4'd2;
            3'd4:    slope = 4'd3;
            3'd5:    slope = 4'd4;
            3'd6:    slope = 4'd5;
            3'd7:    slope = 4'd7;
            default: slope = 4'd1;
        endcase
    end

endmodule

`default_nettype wire

/* shifter/nabp_shifter_fsm.sv */
`timescale 1ns/1ns
`default_nettype none

module nabp_shifter_fsm
(
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          fill_kick,
    input  logic                          shift_kick,
    input  logic                          fill_last,
    input  logic                          shift_last,
    input  logic                          carry,
    output nabp_state_pkg::shifter_state_t state,
    output logic                          fill_done,
    output logic                          shift_done,
    output logic                          shift_enable
);

    nabp_state_pkg::shifter_state_t next_state;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= nabp_state_pkg::ready_s;
        end
        else
        begin
            state <= next_state;
        end
    end

    // mealy done pulses, in the last cycle of each phase
    assign fill_done  = fill_last && (state == nabp_state_pkg::fill_s);
    assign shift_done = shift_last && (state == nabp_state_pkg::shift_s);

    // kicks outside their own state fall through
    always_comb
    begin
        next_state = state;
        case (state)
            nabp_state_pkg::ready_s:
                if (fill_kick)
                    next_state = nabp_state_pkg::fill_s;
            nabp_state_pkg::fill_s:
                if (fill_done)
                    next_state = nabp_state_pkg::fill_done_s;
            nabp_state_pkg::fill_done_s:
                if (shift_kick)
                    next_state = nabp_state_pkg::shift_s;
            nabp_state_pkg::shift_s:
                if (shift_done)
                    next_state = nabp_state_pkg::ready_s;
            default:
                next_state = nabp_state_pkg::ready_s;
        endcase
    end

    // mapper advances every fill cycle, only on carries while shifting
    always_comb
    begin
        case (state)
            nabp_state_pkg::fill_s:
                shift_enable = 1'b1;
            nabp_state_pkg::shift_s:
                shift_enable = carry;
            default:
                shift_enable = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* shifter/nabp_shift_counters.sv */
`timescale 1ns/1ns
`default_nettype none

`include "nabp_defines.svh"

module nabp_shift_counters
(
    input  logic                           clk,
    input  logic                           reset_n,
    input  nabp_state_pkg::shifter_state_t state,
    input  nabp_fixed_pkg::slope_t         slope,
    output logic                           fill_last,
    output logic                           shift_last,
    output logic                           carry
);

    localparam int fill_cnt_width  = $clog2(`NABP_FILL_LEN);
    localparam int shift_cnt_width = $clog2(`NABP_IMAGE_SIZE);
    localparam int accu_width      = $bits(nabp_fixed_pkg::accu_word_t);

    logic [fill_cnt_width-1:0]  fill_cnt;
    logic [shift_cnt_width-1:0] shift_cnt;
    nabp_fixed_pkg::slope_t     slope_q;
    nabp_fixed_pkg::accu_word_t accu;
    nabp_fixed_pkg::accu_word_t accu_sum;

    // slope held steady for the whole row
    always_ff @(posedge clk)
    begin
        if (state != nabp_state_pkg::shift_s)
            slope_q <= slope;
    end

    // down-counters reload whenever their phase is not running
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            fill_cnt  <= fill_cnt_width'(`NABP_FILL_LEN - 1);
            shift_cnt <= shift_cnt_width'(`NABP_IMAGE_SIZE - 1);
            accu.raw  <= '0;
        end
        else
        begin
            if (state == nabp_state_pkg::fill_s && fill_cnt != 0)
                fill_cnt <= fill_cnt - 1'b1;
            else
                fill_cnt <= fill_cnt_width'(`NABP_FILL_LEN - 1);

            if (state == nabp_state_pkg::shift_s && shift_cnt != 0)
                shift_cnt <= shift_cnt - 1'b1;
            else
                shift_cnt <= shift_cnt_width'(`NABP_IMAGE_SIZE - 1);

            if (state == nabp_state_pkg::shift_s)
                accu.raw <= accu_sum.raw;
            else
                accu.raw <= '0;
        end
    end

    assign accu_sum.raw = accu.raw + accu_width'(slope_q);

    // integer part stepping means the row moved by a whole sample
    assign carry = accu_sum.fields.int_part != accu.fields.int_part;

    assign fill_last  = (state == nabp_state_pkg::fill_s) && (fill_cnt == 0);
    assign shift_last = (state == nabp_state_pkg::shift_s) && (shift_cnt == 0);

endmodule

`default_nettype wire

/* rtl/nabp_filter_mapper.sv */
`timescale 1ns/1ns
`default_nettype none

`include "nabp_defines.svh"

module nabp_filter_mapper
(
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          shift_enable,
    input  logic [`NABP_SAMPLE_WIDTH-1:0] sample_in,
    output logic [`NABP_SAMPLE_WIDTH-1:0] mapper_head
);

    logic [`NABP_SAMPLE_WIDTH-1:0] taps [`NABP_MAPPER_DEPTH];

    // new sample enters tap 0, oldest sits at the far end
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            for (int i = 0; i < `NABP_MAPPER_DEPTH; i++)
                taps[i] <= '0;
        end
        else if (shift_enable)
        begin
            taps[0] <= sample_in;
            for (int i = 1; i < `NABP_MAPPER_DEPTH; i++)
                taps[i] <= taps[i-1];
        end
    end

    assign mapper_head = taps[`NABP_MAPPER_DEPTH-1];

endmodule

`default_nettype wire

/* rtl/nabp_shifter_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "nabp_defines.svh"

module nabp_shifter_top
(
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          fill_kick,
    input  logic                          shift_kick,
    input  logic [`NABP_ANGLE_WIDTH-1:0]  angle,
    input  logic [`NABP_SAMPLE_WIDTH-1:0] sample_in,
    output logic                          fill_done,
    output logic                          shift_done,
    output logic                          shift_enable,
    output logic [`NABP_SAMPLE_WIDTH-1:0] mapper_head
);

    nabp_fixed_pkg::slope_t         slope;
    nabp_state_pkg::shifter_state_t state;
    logic                           fill_last;
    logic                           shift_last;
    logic                           carry;

    nabp_slope_table u_slope_table (
        .angle (angle),
        .slope (slope)
    );

    nabp_shifter_fsm u_fsm (
        .clk          (clk),
        .reset_n      (reset_n),
        .fill_kick    (fill_kick),
        .shift_kick   (shift_kick),
        .fill_last    (fill_last),
        .shift_last   (shift_last),
        .carry        (carry),
        .state        (state),
        .fill_done    (fill_done),
        .shift_done   (shift_done),
        .shift_enable (shift_enable)
    );

    nabp_shift_counters u_counters (
        .clk        (clk),
        .reset_n    (reset_n),
        .state      (state),
        .slope      (slope),
        .fill_last  (fill_last),
        .shift_last (shift_last),
        .carry      (carry)
    );

    nabp_filter_mapper u_mapper (
        .clk          (clk),
        .reset_n      (reset_n),
        .shift_enable (shift_enable),
        .sample_in    (sample_in),
        .mapper_head  (mapper_head)
    );

endmodule

`default_nettype wire

/* sim/nabp_shifter_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "nabp_defines.svh"

module nabp_shifter_tb;

    logic                          clk;
    logic                          reset_n;
    logic                          fill_kick;
    logic                          shift_kick;
    logic [`NABP_ANGLE_WIDTH-1:0]  angle;
    logic [`NABP_SAMPLE_WIDTH-1:0] sample_in;
    logic                          fill_done;
    logic                          shift_done;
    logic                          shift_enable;
    logic [`NABP_SAMPLE_WIDTH-1:0] mapper_head;

    int          errors;
    int          tests_passed;
    int          tests_failed;
    int          cycle_limit;
    bit          loaded;
    string       cur_test;
    logic [31:0] lcg_state;

    // mapper model, index 0 is tap 0
    logic [`NABP_SAMPLE_WIDTH-1:0] model_q[$];

    string test_names[$];
    int    test_angles[$];
    int    test_counts[$];

    nabp_shifter_top dut (
        .clk          (clk),
        .reset_n      (reset_n),
        .fill_kick    (fill_kick),
        .shift_kick   (shift_kick),
        .angle        (angle),
        .sample_in    (sample_in),
        .fill_done    (fill_done),
        .shift_done   (shift_done),
        .shift_enable (shift_enable),
        .mapper_head  (mapper_head)
    );

    always #50 clk = ~clk;

    function automatic logic [`NABP_SAMPLE_WIDTH-1:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    // slope in eighths per angle
    function automatic int table_slope(input int a);
        case (a)
            0: return 1;
            1: return 1;
            2: return 2;
            3: return 2;
            4: return 3;
            5: return 4;
            6: return 5;
            default: return 7;
        endcase
    endfunction

    // integer part of the fixed-point accumulator steps when the slope is added
    function automatic bit row_carry(input int acc, input int slope);
        return ((acc + slope) >> `NABP_FRAC_WIDTH) != (acc >> `NABP_FRAC_WIDTH);
    endfunction

    // step a fixed-point accumulator over one row, count integer crossings
    function automatic int expected_shifts(input int slope);
        int acc;
        int n;
        acc = 0;
        n = 0;
        for (int i = 0; i < `NABP_IMAGE_SIZE; i++)
        begin
            if (row_carry(acc, slope))
                n++;
            acc = acc + slope;
        end
        return n;
    endfunction

    task automatic report_mismatch(input string what, input int expected, input int actual);
        $display("[ERROR] %s: %s expected %0d, actual %0d", cur_test, what, expected, actual);
        errors++;
    endtask

    task automatic report_problem(input string what);
        $display("[ERROR] %s: %s", cur_test, what);
        errors++;
    endtask

    // sample at the falling edge, then drive the next inputs after the rising edge
    task automatic run_cycle(input bit exp_en, output bit en, output bit fd, output bit sd);
        @(negedge clk);
        en = shift_enable;
        fd = fill_done;
        sd = shift_done;
        if (shift_enable !== exp_en)
            report_mismatch("shift_enable", int'(exp_en), int'(shift_enable));
        if (mapper_head !== model_q[`NABP_MAPPER_DEPTH-1])
            report_mismatch("mapper_head", int'(model_q[`NABP_MAPPER_DEPTH-1]),
                            int'(mapper_head));
        // model advances on the expected enable
        if (exp_en)
        begin
            model_q.push_front(sample_in);
            void'(model_q.pop_back());
        end
        @(posedge clk);
        #5;
        fill_kick  = 1'b0;
        shift_kick = 1'b0;
        sample_in  = lcg_next();
    endtask

    task automatic reset_idle_check();
        bit en;
        bit fd;
        bit sd;
        int err_before;
        cur_test = "reset_idle";
        err_before = errors;
        if (mapper_head !== '0)
            report_mismatch("mapper_head after reset", 0, int'(mapper_head));
        for (int i = 0; i < 2; i++)
        begin
            run_cycle(1'b0, en, fd, sd);
            if (en || fd || sd)
                report_problem("outputs active after reset before any kick");
        end
        if (errors == err_before)
            tests_passed++;
        else
            tests_failed++;
        $display("test %s : %s", cur_test, (errors == err_before) ? "pass" : "fail");
    endtask

    task automatic run_angle_test(input int idx);
        bit en;
        bit fd;
        bit sd;
        bit exp_en;
        int n_cyc;
        int n_en;
        int slope;
        int acc;
        int exp_model;
        int err_before;
        cur_test = test_names[idx];
        err_before = errors;
        slope = table_slope(test_angles[idx]);
        exp_model = expected_shifts(slope);
        if (exp_model != test_counts[idx])
            report_mismatch("data file shift count", exp_model, test_counts[idx]);
        angle = test_angles[idx][`NABP_ANGLE_WIDTH-1:0];

        // a shift kick in the ready state goes nowhere
        shift_kick = 1'b1;
        run_cycle(1'b0, en, fd, sd);
        if (en || fd || sd)
            report_problem("activity after a shift kick in the ready state");
        fill_kick = 1'b1;
        run_cycle(1'b0, en, fd, sd);
        if (en || fd || sd)
            report_problem("activity in the fill kick cycle");

        // fill phase
        n_cyc = 0;
        n_en = 0;
        fd = 1'b0;
        while (!fd && n_cyc < 2 * `NABP_FILL_LEN)
        begin
            run_cycle(n_cyc < `NABP_FILL_LEN, en, fd, sd);
            n_cyc++;
            if (en)
                n_en++;
            if (sd)
                report_problem("shift_done pulsed during the fill phase");
        end
        if (!fd)
            report_problem("fill_done never pulsed");
        if (n_cyc != `NABP_FILL_LEN)
            report_mismatch("fill cycles", `NABP_FILL_LEN, n_cyc);
        if (n_en != `NABP_FILL_LEN)
            report_mismatch("fill enables", `NABP_FILL_LEN, n_en);

        run_cycle(1'b0, en, fd, sd);
        if (en || fd || sd)
            report_problem("activity while waiting after fill done");
        shift_kick = 1'b1;
        run_cycle(1'b0, en, fd, sd);
        if (en || fd || sd)
            report_problem("activity in the shift kick cycle");

        // shift phase, with a stray fill kick in its first cycle
        n_cyc = 0;
        n_en = 0;
        acc = 0;
        sd = 1'b0;
        fill_kick = 1'b1;
        while (!sd && n_cyc < 2 * `NABP_IMAGE_SIZE)
        begin
            exp_en = (n_cyc < `NABP_IMAGE_SIZE) && row_carry(acc, slope);
            run_cycle(exp_en, en, fd, sd);
            acc = acc + slope;
            n_cyc++;
            if (en)
                n_en++;
            if (fd)
                report_problem("fill_done pulsed during the shift phase");
        end
        if (!sd)
            report_problem("shift_done never pulsed");
        if (n_cyc != `NABP_IMAGE_SIZE)
            report_mismatch("shift cycles", `NABP_IMAGE_SIZE, n_cyc);
        if (n_en != exp_model)
            report_mismatch("shift enables vs model", exp_model, n_en);
        if (n_en != test_counts[idx])
            report_mismatch("shift enables vs data file", test_counts[idx], n_en);

        run_cycle(1'b0, en, fd, sd);
        if (en || fd || sd)
            report_problem("activity after shift_done");

        if (errors == err_before)
            tests_passed++;
        else
            tests_failed++;
        $display("test %s angle %0d shifts %0d : %s", cur_test, test_angles[idx], n_en,
                 (errors == err_before) ? "pass" : "fail");
    endtask

    initial
    begin
        int    fh;
        int    code;
        int    ang;
        int    cnt;
        string line;
        string name;
        clk = 1'b0;
        reset_n = 1'b0;
        fill_kick = 1'b0;
        shift_kick = 1'b0;
        angle = '0;
        sample_in = '0;
        errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        lcg_state = 32'd62;
        cur_test = "setup";
        for (int i = 0; i < `NABP_MAPPER_DEPTH; i++)
            model_q.push_back('0);

        fh = $fopen("sim/nabp_shifter_testdata.txt", "r");
        if (fh == 0)
        begin
            report_problem("could not open sim/nabp_shifter_testdata.txt");
        end
        else
        begin
            while (!$feof(fh))
            begin
                line = "";
                code = $fgets(line, fh);
                // skip comments and blank lines
                if (code > 1 && line[0] != "#")
                begin
                    code = $sscanf(line, "%s %d %d", name, ang, cnt);
                    if (code == 3)
                    begin
                        test_names.push_back(name);
                        test_angles.push_back(ang);
                        test_counts.push_back(cnt);
                    end
                end
            end
            $fclose(fh);
        end
        if (test_names.size() == 0)
            report_problem("no tests were read from the data file");
        cycle_limit = test_names.size() * (`NABP_FILL_LEN + `NABP_IMAGE_SIZE + 10) + 50;
        loaded = 1'b1;

        repeat (10) @(posedge clk);
        #5;
        reset_n = 1'b1;

        reset_idle_check();
        for (int i = 0; i < test_names.size(); i++)
            run_angle_test(i);

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 tests_passed + tests_failed, tests_passed, tests_failed, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    // run limit from the number of tests
    initial
    begin
        int cycles;
        cycles = 0;
        wait (loaded);
        while (cycles < cycle_limit)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* nabp_shifter.f */
+incdir+common
common/nabp_fixed_pkg.sv
common/nabp_state_pkg.sv
rtl/nabp_slope_table.sv
shifter/nabp_shifter_fsm.sv
shifter/nabp_shift_counters.sv
rtl/nabp_filter_mapper.sv
rtl/nabp_shifter_top.sv
sim/nabp_shifter_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the shifter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --timescale 1ns/1ns \
    --top-module nabp_shifter_tb -f nabp_shifter.f

./obj_dir/Vnabp_shifter_tb | tee run_sim.log

if grep -q "^No errors$" run_sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1

/* sim/nabp_shifter_testdata.txt */
# columns: test name, angle (0 to 7), expected shift_enable count in the shift phase
# first block walks the angles in order, second block runs them back to back in mixed order
angle_0 0 1
angle_1 1 1
angle_2 2 2
angle_3 3 2
angle_4 4 3
angle_5 5 4
angle_6 6 5
angle_7 7 7
b2b_7 7 7
b2b_3 3 2
b2b_0 0 1
b2b_5 5 4
b2b_6 6 5
b2b_1 1 1
b2b_4 4 3
b2b_2 2 2
